// ==== project.f ====
ppuPkg.sv
vgaTiming.sv
ppuRegDecode.sv
bgFetch.sv
pixelOutput.sv
ppuTop.sv
ppuTb.sv

// ==== Bender.yml ====
package:
  name: ppu

sources:
  - ppuPkg.sv
  - vgaTiming.sv
  - ppuRegDecode.sv
  - bgFetch.sv
  - pixelOutput.sv
  - ppuTop.sv
  - target: test
    files:
      - ppuTb.sv

// ==== ppuTb.sv ====
// Random CPU accesses from a fixed seed; memory models are read-only, palette written before reads
`default_nettype none

module ppuTb;

    import ppuPkg::*;

    localparam int lineClocks  = 800;
    localparam int frameClocks = 800 * 525;

    logic        CLK25;
    logic        RESET;
    logic [15:0] ea;
    logic  [7:0] din;
    logic        RD;
    logic        WREQ;
    logic  [7:0] DOUT;
    logic  [7:0] VIN;
    logic  [7:0] FIN;
    logic        WVREQ;
    logic [15:0] WADDR;
    logic  [7:0] WDATA;
    logic [10:0] vaddr;
    logic  [7:0] vdata;
    logic [12:0] faddr;
    logic  [7:0] fdata;
    logic  [4:0] red;
    logic  [5:0] green;
    logic  [4:0] blue;
    logic        hs;
    logic        vs;
    logic        NMI;

    int          errorCount;
    int          checkCount;
    int unsigned seedVal;
    logic [15:0] start;
    logic        vsSeen;         // Last vs wait ended in time

    // --------------------
    // Reference model state
    logic  [7:0] mCtrl0;
    logic  [7:0] mCtrl1;
    logic [15:0] mAddr;
    logic        mFirst;         // Next address write is the high byte
    logic  [7:0] mBuf;           // Read buffer
    logic        mVblank;
    logic  [5:0] mPal [32];
    logic  [7:0] ntMem [2048];   // Name table and attribute bytes
    logic  [7:0] patMem [8192];  // Pattern planes
    logic  [7:0] tileNum;        // Tile used everywhere in the pixel test
    logic  [1:0] attrBits;

    ppuTop dut_i (
        .CLK25(CLK25), .RESET(RESET), .ea(ea), .din(din), .RD(RD), .WREQ(WREQ),
        .DOUT(DOUT), .VIN(VIN), .FIN(FIN), .WVREQ(WVREQ), .WADDR(WADDR), .WDATA(WDATA),
        .vaddr(vaddr), .vdata(vdata), .faddr(faddr), .fdata(fdata),
        .red(red), .green(green), .blue(blue), .hs(hs), .vs(vs), .NMI(NMI)
    );

    initial begin
        CLK25 = 1'b0;
        forever #2 CLK25 = ~CLK25;
    end

    // Memories answer the address of the previous edge
    initial begin
        vdata = '0;
        fdata = '0;
        forever begin
            @(negedge CLK25);
            vdata = ntMem[vaddr];
            fdata = patMem[faddr];
        end
    end

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
        $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, expected);
        errorCount++;
    endtask

    task automatic writeReg(input logic [2:0] idx, input logic [7:0] data);
        logic        expWvreq;
        logic [15:0] expWaddr;
        expWvreq = (idx == regData) && (mAddr < paletteBase);
        expWaddr = mAddr;
        ea   = {ppuWindowTop, 10'($urandom), idx}; // Random mirror of the register
        din  = data;
        WREQ = 1'b1;
        @(negedge CLK25);
        WREQ = 1'b0;
        checkCount++;
        if (WVREQ !== expWvreq)
            reportMismatch("WVREQ", WVREQ, expWvreq);
        if (expWvreq && WADDR !== expWaddr)
            reportMismatch("WADDR", WADDR, expWaddr);
        if (expWvreq && WDATA !== data)
            reportMismatch("WDATA", WDATA, data);
        @(negedge CLK25);
        if (WVREQ !== 1'b0)
            reportMismatch("WVREQ", WVREQ, 1'b0); // One pulse only
        case (idx)
            regCtrl0: mCtrl0 = data;
            regCtrl1: mCtrl1 = data;
            regAddr: begin
                if (mFirst)
                    mAddr[15:8] = data;
                else
                    mAddr[7:0] = data;
                mFirst = !mFirst;
            end
            regData: begin
                if (mAddr >= paletteBase && mAddr < paletteEnd)
                    mPal[mAddr[4:0]] = data[5:0];
                mAddr = mAddr + (mCtrl0[2] ? 16'd32 : 16'd1);
            end
            default: ;
        endcase
    endtask

    task automatic readReg(input logic [2:0] idx);
        logic [7:0] expected;
        expected = 8'h00;
        VIN = ntMem[mAddr[10:0]];   // Memory contents at ADDR
        FIN = patMem[mAddr[12:0]];
        if (idx == regStatus) begin
            expected = {mVblank, 2'b00, mVblank, 4'h0};
            mFirst   = 1'b1;
            mVblank  = 1'b0;
        end else begin
            if (mAddr < paletteBase) begin
                expected = mBuf;    // Old buffer out and refill from memory
                mBuf     = (mAddr < 16'h2000) ? patMem[mAddr[12:0]] : ntMem[mAddr[10:0]];
            end else if (mAddr < paletteEnd)
                expected = {2'b00, mPal[mAddr[4:0]]};
            mAddr = mAddr + (mCtrl0[2] ? 16'd32 : 16'd1);
        end
        ea = {ppuWindowTop, 10'($urandom), idx};
        RD = 1'b1;
        @(negedge CLK25);
        RD = 1'b0;
        checkCount++;
        if (DOUT !== expected)
            reportMismatch("DOUT", DOUT, expected);
    endtask

    task automatic setVideoAddr(input logic [15:0] value);
        writeReg(regAddr, value[15:8]); // High byte first
        writeReg(regAddr, value[7:0]);
    endtask

    // Returns on the clock where vs goes high at line 490 column 0
    task automatic waitVsRise(output logic found);
        int   n;
        logic prev;
        n     = 0;
        prev  = 1'b1;
        found = 1'b0;
        while (!found && n <= frameClocks + lineClocks) begin
            prev = vs;
            @(negedge CLK25);
            n++;
            found = vs && !prev;
        end
        if (!found) begin
            $display("Timeout: vs did not rise within one frame");
            errorCount++;
        end
    endtask

    // Colour of VGA column c on line v packed as {red, green, blue}
    function automatic logic [15:0] expectedRgb(input int c, input int v);
        int          px;
        logic  [2:0] bitPos;
        logic  [7:0] lo;
        logic  [7:0] hi;
        logic  [4:0] palIdx;
        logic [15:0] word;
        palIdx = 5'd0; // Backdrop
        if (c >= bgLeft && c < bgRight && v < 480) begin
            px     = (c - bgLeft) / 2;           // PPU pixel
            bitPos = 3'(7 - px % 8);             // Leftmost pixel in bit 7
            lo     = patMem[{mCtrl0[4], tileNum, 1'b0, 3'((v / 2) % 8)}];
            hi     = patMem[{mCtrl0[4], tileNum, 1'b1, 3'((v / 2) % 8)}];
            if (mCtrl1[3] && {hi[bitPos], lo[bitPos]} != 2'b00
                && (mCtrl1[1] || c >= bgLeft + 16))
                palIdx = {1'b0, attrBits, hi[bitPos], lo[bitPos]};
        end
        word = systemPalette[mPal[palIdx]];
        return {word[4:0], word[10:5], word[15:11]}; // Red sits in the low bits
    endfunction

    // --------------------
    // One full frame from the vs rise
    task automatic checkFrame;
        int          h;
        int          v;
        logic [15:0] expRgb;
        h = 0;
        v = 490;
        repeat (frameClocks) begin
            expRgb = 16'h0000;
            if (h >= 2 && h < 642 && v < 480)
                expRgb = expectedRgb(h - 2, v); // RGB two clocks behind hPos
            checkCount++;
            if ({red, green, blue} !== expRgb)
                reportMismatch("{red,green,blue}", {red, green, blue}, expRgb);
            if (hs !== (h >= 656 && h < 752))
                reportMismatch("hs", hs, (h >= 656 && h < 752));
            if (vs !== (v >= 490 && v < 492))
                reportMismatch("vs", vs, (v >= 490 && v < 492));
            if (NMI !== 1'b0)
                reportMismatch("NMI", NMI, 1'b0); // NMI enable is off here
            h++;
            if (h == lineClocks) begin
                h = 0;
                v = (v == 524) ? 0 : v + 1;
            end
            @(negedge CLK25);
        end
    endtask

    task automatic fillAddressPattern;
        for (int i = 0; i < 8192; i++) begin
            patMem[i] = 8'((i * 29) ^ (i >> 5));
            if (i < 2048)
                ntMem[i] = 8'(i * 7 + (i >> 8) * 13 + 5);
        end
    endtask

    task automatic fillTiles;
        for (int i = 0; i < 2048; i++)
            ntMem[i] = (((i >> 6) & 15) == 15) ? {4{attrBits}} : tileNum; // Attribute area
    endtask

    task automatic reportAndFinish;
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    endtask

    initial begin
        seedVal    = $urandom(73262);
        errorCount = 0;
        checkCount = 0;
        vsSeen     = 1'b1;
        RESET = 1'b1;
        ea    = '0;
        din   = '0;
        RD    = 1'b0;
        WREQ  = 1'b0;
        VIN   = '0;
        FIN   = '0;
        mCtrl0   = '0;
        mCtrl1   = '0;
        mAddr    = '0;
        mFirst   = 1'b1;
        mBuf     = 8'hFF;
        mVblank  = 1'b0;
        tileNum  = '0;
        attrBits = '0;
        fillAddressPattern;
        repeat (2) @(posedge CLK25);
        @(negedge CLK25);
        checkCount++;
        if ({red, green, blue} !== 16'h0000)
            reportMismatch("{red,green,blue}", {red, green, blue}, 16'h0000);
        if (WVREQ !== 1'b0 || NMI !== 1'b0)
            reportMismatch("{WVREQ,NMI}", {WVREQ, NMI}, 2'b00);
        RESET = 1'b0;
        @(negedge CLK25);

        // -------------------- Buffered reads starting from the 0xFF reset value
        for (int burst = 0; burst < 2; burst++) begin
            writeReg(regCtrl0, {5'b0, 1'($urandom), 2'b0});
            if (burst == 0)
                setVideoAddr(16'($urandom % 16'h2000));          // Pattern space
            else
                setVideoAddr(16'h2000 + 16'($urandom % 16'h1E00)); // Name tables
            repeat (6) readReg(regData);
        end

        // -------------------- VRAM writes
        writeReg(regCtrl0, {5'b0, 1'($urandom), 2'b0});
        setVideoAddr(16'($urandom % 16'h3E00));
        repeat (5) writeReg(regData, 8'($urandom));

        // -------------------- Palette port
        writeReg(regCtrl0, 8'h00);
        setVideoAddr(paletteBase);
        repeat (32) writeReg(regData, 8'($urandom)); // Whole palette known
        repeat (8) begin
            writeReg(regCtrl0, {5'b0, 1'($urandom), 2'b0});
            start = paletteBase + 16'(5'($urandom));
            setVideoAddr(start);
            repeat (3) writeReg(regData, 8'($urandom));
            setVideoAddr(start);
            repeat (3) readReg(regData);
        end

        // -------------------- VBlank and NMI with enable off then on
        for (int k = 0; k < 2 && vsSeen; k++) begin
            writeReg(regCtrl0, {1'(k), 7'($urandom)});
            waitVsRise(vsSeen);
            if (vsSeen) begin
                mVblank = 1'b1; // Set at line 480
                checkCount++;
                if (NMI !== mCtrl0[7])
                    reportMismatch("NMI", NMI, mCtrl0[7]);
                readReg(regStatus);
                readReg(regStatus); // Flag now clear
                checkCount++;
                if (NMI !== 1'b0)
                    reportMismatch("NMI", NMI, 1'b0);
            end
        end

        // -------------------- Pixel colour with background on then off
        if (vsSeen) begin
            tileNum  = 8'($urandom);
            attrBits = 2'($urandom);
            fillTiles;
            writeReg(regCtrl0, 8'h00);
            setVideoAddr(paletteBase);
            repeat (16) writeReg(regData, 8'($urandom));
            writeReg(regCtrl0, {1'b0, 7'($urandom)});
            writeReg(regCtrl1, 8'($urandom) | 8'h08);
            waitVsRise(vsSeen);
        end
        if (vsSeen) begin
            checkFrame;
            writeReg(regCtrl1, 8'($urandom) & 8'hF7);
            waitVsRise(vsSeen);
        end
        if (vsSeen)
            checkFrame;

        reportAndFinish;
    end

endmodule

`default_nettype wire

// ==== ppuTop.sv ====
// Single clock domain on CLK25; timing parameters must keep the 640x480 window layout
`default_nettype none

module ppuTop #(
    parameter int hVisible = ppuPkg::hVisibleDef,
    parameter int hFront   = ppuPkg::hFrontDef,
    parameter int hSync    = ppuPkg::hSyncDef,
    parameter int hBack    = ppuPkg::hBackDef,
    parameter int vVisible = ppuPkg::vVisibleDef,
    parameter int vFront   = ppuPkg::vFrontDef,
    parameter int vSync    = ppuPkg::vSyncDef,
    parameter int vBack    = ppuPkg::vBackDef
) (
    input  wire logic        CLK25,
    input  wire logic        RESET,
    input  wire logic [15:0] ea,     // CPU bus
    input  wire logic  [7:0] din,
    input  wire logic        RD,
    input  wire logic        WREQ,
    output logic       [7:0] DOUT,
    input  wire logic  [7:0] VIN,    // Memory contents at the video address
    input  wire logic  [7:0] FIN,
    output logic             WVREQ,  // VRAM write request
    output logic      [15:0] WADDR,
    output logic       [7:0] WDATA,
    output logic      [10:0] vaddr,  // Name table port
    input  wire logic  [7:0] vdata,
    output logic      [12:0] faddr,  // Pattern port
    input  wire logic  [7:0] fdata,
    output logic       [4:0] red,
    output logic       [5:0] green,
    output logic       [4:0] blue,
    output logic             hs,
    output logic             vs,
    output logic             NMI
);

    logic [9:0] hPos;
    logic [9:0] vPos;
    logic       visible;
    logic       frameStart;
    logic       vblankStart;
    logic       ntSelect;
    logic       bgPatternSel;
    logic       bgEnable;
    logic       bgLeftShow;
    logic       palWrite;
    logic [4:0] palAddr;
    logic [5:0] palWrData;
    logic [5:0] palRdData;
    logic [3:0] bgIndex;

    vgaTiming #(
        .hVisible(hVisible), .hFront(hFront), .hSync(hSync), .hBack(hBack),
        .vVisible(vVisible), .vFront(vFront), .vSync(vSync), .vBack(vBack)
    ) timingI (
        .CLK25(CLK25), .RESET(RESET), .hPos(hPos), .vPos(vPos), .hs(hs), .vs(vs),
        .visible(visible), .frameStart(frameStart), .vblankStart(vblankStart)
    );

    // Decode: CPU register port
    ppuRegDecode regI (
        .CLK25(CLK25), .RESET(RESET), .ea(ea), .din(din), .RD(RD), .WREQ(WREQ),
        .VIN(VIN), .FIN(FIN), .frameStart(frameStart), .vblankStart(vblankStart),
        .palRdData(palRdData), .DOUT(DOUT), .WVREQ(WVREQ), .WADDR(WADDR), .WDATA(WDATA),
        .NMI(NMI), .ntSelect(ntSelect), .bgPatternSel(bgPatternSel), .bgEnable(bgEnable),
        .bgLeftShow(bgLeftShow), .palWrite(palWrite), .palAddr(palAddr),
        .palWrData(palWrData)
    );

    // Execute: background tile fetch
    bgFetch fetchI (
        .CLK25(CLK25), .RESET(RESET), .hPos(hPos), .vPos(vPos), .vdata(vdata),
        .fdata(fdata), .ntSelect(ntSelect), .bgPatternSel(bgPatternSel),
        .vaddr(vaddr), .faddr(faddr), .bgIndex(bgIndex)
    );

    // Result: palette and colour
    pixelOutput pixelI (
        .CLK25(CLK25), .RESET(RESET), .hPos(hPos), .vPos(vPos), .visible(visible),
        .bgIndex(bgIndex), .bgEnable(bgEnable), .bgLeftShow(bgLeftShow),
        .palWrite(palWrite), .palAddr(palAddr), .palWrData(palWrData),
        .palRdData(palRdData), .red(red), .green(green), .blue(blue)
    );

endmodule

`default_nettype wire

// ==== pixelOutput.sv ====
// Only the background half of the palette is displayed; RGB is black during reset and blanking
`default_nettype none

module pixelOutput (
    input  wire logic       CLK25,
    input  wire logic       RESET,
    input  wire logic [9:0] hPos,
    input  wire logic [9:0] vPos,
    input  wire logic       visible,
    input  wire logic [3:0] bgIndex,
    input  wire logic       bgEnable,
    input  wire logic       bgLeftShow,
    input  wire logic       palWrite,
    input  wire logic [4:0] palAddr,
    input  wire logic [5:0] palWrData,
    output logic      [5:0] palRdData,
    output logic      [4:0] red,
    output logic      [5:0] green,
    output logic      [4:0] blue
);

    import ppuPkg::*;

    localparam logic [9:0] leftEdge  = 10'(bgLeft);
    localparam logic [9:0] rightEdge = 10'(bgRight);
    localparam logic [9:0] leftMask  = 10'(bgLeft + 16); // First 8 PPU pixels
    localparam logic [9:0] bgBottom  = 10'd480;          // 240 PPU lines doubled

    // Background colours at power-up, sprite half black
    localparam logic [5:0] palInit [32] = '{
        6'h12, 6'h16, 6'h30, 6'h38, 6'h00, 6'h17, 6'h26, 6'h07,
        6'h00, 6'h16, 6'h00, 6'h30, 6'h00, 6'h38, 6'h28, 6'h10,
        6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00,
        6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00
    };

    logic          [5:0] palRam [32];
    logic                visibleD;   // Visibility of column hPos-1
    logic          [9:0] col;
    logic                inWindow;
    logic                showBg;
    logic          [4:0] palIdx;
    logic          [5:0] colour;
    logic [rgbWidth-1:0] rgb;

    // --------------------
    // Palette RAM
    always_ff @(posedge CLK25) begin
        if (RESET)
            palRam <= palInit;
        else if (palWrite)
            palRam[palAddr] <= palWrData;
    end

    assign palRdData = palRam[palAddr];

    // bgIndex belongs to the previous column
    assign col      = hPos - 10'd1;
    assign inWindow = (col >= leftEdge) && (col < rightEdge) && (vPos < bgBottom);
    assign showBg   = bgEnable && inWindow && (bgIndex[1:0] != 2'b00)
                      && (bgLeftShow || col >= leftMask);
    assign palIdx   = showBg ? {1'b0, bgIndex} : 5'd0; // Backdrop otherwise
    assign colour   = palRam[palIdx];
    assign rgb      = systemPalette[colour];

    // --------------------
    always_ff @(posedge CLK25) begin
        if (RESET) begin
            visibleD <= 1'b0;
            {red, green, blue} <= '0;
        end else begin
            visibleD <= visible;
            if (visibleD)
                {red, green, blue} <= {rgb[4:0], rgb[10:5], rgb[15:11]}; // Red in low bits
            else
                {red, green, blue} <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== bgFetch.sv ====
// No scrolling; memories must return data one clock after vaddr/faddr, bgIndex lags hPos by one
`default_nettype none

module bgFetch (
    input  wire logic        CLK25,
    input  wire logic        RESET,
    input  wire logic  [9:0] hPos,
    input  wire logic  [9:0] vPos,
    input  wire logic  [7:0] vdata,
    input  wire logic  [7:0] fdata,
    input  wire logic        ntSelect,
    input  wire logic        bgPatternSel,
    output logic      [10:0] vaddr,
    output logic      [12:0] faddr,
    output logic       [3:0] bgIndex
);

    import ppuPkg::*;

    localparam logic [9:0] fetchOffset = 10'(16 - bgLeft); // One tile slot ahead
    localparam logic [9:0] winOffset   = 10'(bgLeft);

    logic [9:0] fetchX;   // Window column of the tile being fetched
    logic [9:0] winX;     // Window column being shown
    logic [4:0] tileCol;
    logic [4:0] tileRow;
    logic [2:0] fineY;
    logic [2:0] bitSel;
    logic [7:0] nextLo;
    logic [7:0] nextHi;
    logic [1:0] nextAttr;
    logic [7:0] curLo;
    logic [7:0] curHi;
    logic [1:0] curAttr;

    assign fetchX  = hPos + fetchOffset;
    assign winX    = hPos - winOffset;
    assign tileCol = fetchX[8:4];      // 16 VGA columns per tile
    assign tileRow = vPos[8:4];
    assign fineY   = vPos[3:1];        // Lines doubled
    assign bitSel  = ~winX[3:1];       // Bit 7 is the leftmost pixel

    // --------------------
    // Memory addressing, two clocks per access
    always_ff @(posedge CLK25) begin
        if (RESET) begin
            vaddr   <= '0;
            faddr   <= '0;
            bgIndex <= '0;
        end else begin
            case (fetchX[3:0])
                4'd0: vaddr <= {ntSelect, tileRow, tileCol};   // Name table byte
                4'd2: begin
                    faddr <= {bgPatternSel, vdata, 1'b0, fineY}; // Low plane
                    vaddr <= {ntSelect, 4'b1111, tileRow[4:2], tileCol[4:2]};
                end
                4'd4: faddr[3] <= 1'b1;                          // High plane
                default: ;
            endcase
            bgIndex <= {curAttr, curHi[bitSel], curLo[bitSel]};
        end
    end

    // Tile data capture and load at the slot boundary
    always_ff @(posedge CLK25) begin
        case (fetchX[3:0])
            4'd4: begin
                nextLo   <= fdata;
                nextAttr <= vdata[{tileRow[1], tileCol[1], 1'b0} +: 2]; // Quadrant of 32x32
            end
            4'd6: nextHi <= fdata;
            4'd15: begin
                curLo   <= nextLo;
                curHi   <= nextHi;
                curAttr <= nextAttr;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== ppuRegDecode.sv ====
// CPU accesses are one-cycle RD/WREQ strobes; VRAM writes have no back-pressure, no mirroring
`default_nettype none

module ppuRegDecode (
    input  wire logic        CLK25,
    input  wire logic        RESET,
    input  wire logic [15:0] ea,
    input  wire logic  [7:0] din,
    input  wire logic        RD,
    input  wire logic        WREQ,
    input  wire logic  [7:0] VIN,
    input  wire logic  [7:0] FIN,
    input  wire logic        frameStart,
    input  wire logic        vblankStart,
    input  wire logic  [5:0] palRdData,
    output logic       [7:0] DOUT,
    output logic             WVREQ,
    output logic      [15:0] WADDR,
    output logic       [7:0] WDATA,
    output logic             NMI,
    output logic             ntSelect,
    output logic             bgPatternSel,
    output logic             bgEnable,
    output logic             bgLeftShow,
    output logic             palWrite,
    output logic       [4:0] palAddr,
    output logic       [5:0] palWrData
);

    import ppuPkg::*;

    logic  [7:0] ctrl0;      // NMI enable, increment, pattern and name table select
    logic  [7:0] ctrl1;      // Background enable and left-column show
    logic [15:0] addr;       // Video address
    logic        firstWrite; // Next regAddr write is the high byte
    logic  [7:0] readBuf;    // Delayed VRAM read data
    logic        vblank;
    logic        regSel;
    logic        dataSel;
    logic        statusRead;
    logic        belowPal;
    logic        inPal;
    logic [15:0] addrStep;

    // --------------------
    // Address decode
    assign regSel     = (ea[15:13] == ppuWindowTop);
    assign dataSel    = regSel && (ea[2:0] == regData);
    assign statusRead = RD && regSel && (ea[2:0] == regStatus);
    assign belowPal   = (addr < paletteBase);
    assign inPal      = !belowPal && (addr < paletteEnd);
    assign addrStep   = ctrl0[2] ? 16'd32 : 16'd1; // Across or down

    // --------------------
    // Control state
    always_ff @(posedge CLK25) begin
        if (RESET) begin
            ctrl0      <= '0;
            ctrl1      <= '0;
            addr       <= '0;
            firstWrite <= 1'b1;
            readBuf    <= 8'hFF;
            vblank     <= 1'b0;
            WVREQ      <= 1'b0;
            DOUT       <= '0;
        end else begin
            WVREQ <= WREQ && dataSel && belowPal;

            if (WREQ && regSel) begin
                case (ea[2:0])
                    regCtrl0: ctrl0 <= din;
                    regCtrl1: ctrl1 <= din;
                    regAddr: begin
                        if (firstWrite)
                            addr[15:8] <= din; // High byte first
                        else
                            addr[7:0] <= din;
                        firstWrite <= !firstWrite;
                    end
                    regData: addr <= addr + addrStep;
                    default: ;
                endcase
            end

            if (RD && regSel) begin
                case (ea[2:0])
                    regStatus: begin
                        DOUT       <= {vblank, 2'b00, vblank, 4'h0};
                        firstWrite <= 1'b1;
                    end
                    regData: begin
                        if (belowPal) begin
                            DOUT    <= readBuf;                        // Previous contents
                            readBuf <= (addr < 16'h2000) ? FIN : VIN;  // Pattern or name table
                        end else if (inPal)
                            DOUT <= {2'b00, palRdData};                // Palette is not buffered
                        else
                            DOUT <= 8'h00;
                        addr <= addr + addrStep;
                    end
                    default: ;
                endcase
            end

            // Set wins over a clear on the same clock
            if (vblankStart)
                vblank <= 1'b1;
            else if (frameStart || statusRead)
                vblank <= 1'b0;
        end
    end

    // VRAM write payload
    always_ff @(posedge CLK25) begin
        if (WREQ && dataSel) begin
            WADDR <= addr;
            WDATA <= din;
        end
    end

    assign NMI          = vblank && ctrl0[7];
    assign ntSelect     = ctrl0[0];
    assign bgPatternSel = ctrl0[4];
    assign bgEnable     = ctrl1[3];
    assign bgLeftShow   = ctrl1[1];

    // Palette port, written on the WREQ clock edge
    assign palWrite  = WREQ && dataSel && inPal;
    assign palAddr   = addr[4:0];
    assign palWrData = din[5:0];

endmodule

`default_nettype wire

// ==== vgaTiming.sv ====
// Counters are 10 bits wide, so each total must stay below 1024; sync pulses are active high
`default_nettype none

module vgaTiming #(
    parameter int hVisible = ppuPkg::hVisibleDef,
    parameter int hFront   = ppuPkg::hFrontDef,
    parameter int hSync    = ppuPkg::hSyncDef,
    parameter int hBack    = ppuPkg::hBackDef,
    parameter int vVisible = ppuPkg::vVisibleDef,
    parameter int vFront   = ppuPkg::vFrontDef,
    parameter int vSync    = ppuPkg::vSyncDef,
    parameter int vBack    = ppuPkg::vBackDef
) (
    input  wire logic       CLK25,
    input  wire logic       RESET,
    output logic      [9:0] hPos,
    output logic      [9:0] vPos,
    output logic            hs,
    output logic            vs,
    output logic            visible,
    output logic            frameStart,
    output logic            vblankStart
);

    localparam logic [9:0] hLast      = 10'(hVisible + hFront + hSync + hBack - 1);
    localparam logic [9:0] vLast      = 10'(vVisible + vFront + vSync + vBack - 1);
    localparam logic [9:0] hSyncStart = 10'(hVisible + hFront);
    localparam logic [9:0] hSyncEnd   = 10'(hVisible + hFront + hSync);
    localparam logic [9:0] vSyncStart = 10'(vVisible + vFront);
    localparam logic [9:0] vSyncEnd   = 10'(vVisible + vFront + vSync);

    // Pixel and line counters
    always_ff @(posedge CLK25) begin
        if (RESET) begin
            hPos <= '0;
            vPos <= '0;
        end else if (hPos == hLast) begin
            hPos <= '0;
            vPos <= (vPos == vLast) ? 10'd0 : vPos + 10'd1; // Next line or new frame
        end else begin
            hPos <= hPos + 10'd1;
        end
    end

    assign hs      = (hPos >= hSyncStart) && (hPos < hSyncEnd);
    assign vs      = (vPos >= vSyncStart) && (vPos < vSyncEnd);
    assign visible = (hPos < 10'(hVisible)) && (vPos < 10'(vVisible));

    // Single-clock frame markers at the start of a line
    assign frameStart  = (hPos == 10'd0) && (vPos == 10'd0);
    assign vblankStart = (hPos == 10'd0) && (vPos == 10'(vVisible));

endmodule

`default_nettype wire

// ==== ppuPkg.sv ====
// Shared PPU constants; palette table entries not in the colour table are black (zero)
`default_nettype none

package ppuPkg;

    // --------------------
    // VGA 640x480 timing defaults, in CLK25 pixels and lines
    localparam int hVisibleDef = 640;
    localparam int hFrontDef   = 16;
    localparam int hSyncDef    = 96;
    localparam int hBackDef    = 48;

    localparam int vVisibleDef = 480;
    localparam int vFrontDef   = 10;
    localparam int vSyncDef    = 2;
    localparam int vBackDef    = 33;

    // Background window, 256 PPU pixels doubled to 512 VGA columns
    localparam int bgLeft  = 64;
    localparam int bgRight = 576;

    // --------------------
    // CPU register indices, ea[2:0] inside the 0x2000-0x3FFF window
    localparam logic [2:0] regCtrl0  = 3'd0;
    localparam logic [2:0] regCtrl1  = 3'd1;
    localparam logic [2:0] regStatus = 3'd2;
    localparam logic [2:0] regAddr   = 3'd6;
    localparam logic [2:0] regData   = 3'd7;

    localparam logic [2:0] ppuWindowTop = 3'b001; // ea[15:13]

    // Palette space in the PPU address map
    localparam logic [15:0] paletteBase = 16'h3F00;
    localparam logic [15:0] paletteEnd  = 16'h3F20;

    localparam int rgbWidth = 16; // RGB565

    // --------------------
    // System palette, 6-bit colour number to RGB565
    // Packed with blue in [15:11] and red in [4:0]
    localparam logic [15:0] systemPalette [64] = '{
        16'h73ae, 16'h88c4, 16'ha800, 16'h9808, // 0x00
        16'h7011, 16'h1015, 16'h0014, 16'h004f,
        16'h0168, 16'h0220, 16'h0280, 16'h11e0,
        16'h59e3, 16'h0000, 16'h0000, 16'h0000,
        16'hbdf7, 16'heb80, 16'he9c4, 16'hf010, // 0x10
        16'hb817, 16'h581c, 16'h015b, 16'h0a79,
        16'h0391, 16'h04a0, 16'h0540, 16'h3c80,
        16'h8c00, 16'h0000, 16'h0000, 16'h0000,
        16'hffff, 16'hfde7, 16'hfcab, 16'hfc54, // 0x20
        16'hfbde, 16'hb3bf, 16'h63bf, 16'h3cdf,
        16'h3dfe, 16'h1690, 16'h4ee9, 16'h9fcb,
        16'hdf40, 16'h0000, 16'h0000, 16'h0000,
        16'hffff, 16'hff35, 16'hfeb8, 16'hfe5a, // 0x30
        16'hfe3f, 16'hde3f, 16'hb5ff, 16'haedf,
        16'ha73f, 16'ha7fc, 16'hbf95, 16'hcff6,
        16'hf7f3, 16'h0000, 16'h0000, 16'h0000
    };

endpackage

`default_nettype wire
